// File: common/mapper_pkg.sv
// mapper package: widths, screen geometry, cell grid and palette of the color stage

package mapper_pkg;

    typedef logic [9:0]  coord_t;   // screen x or y
    typedef logic [7:0]  color_t;   // one channel
    typedef logic [23:0] pixel_t;   // {red, green, blue}
    typedef logic [4:0]  row_t;     // cell row
    typedef logic [3:0]  col_t;     // cell column

    // ----------------------------------------
    // cell grid of the well
    localparam int     CELL_COLS   = 10;
    localparam int     CELL_ROWS   = 20;
    localparam coord_t CELL_SIZE   = 10'd20;
    localparam coord_t WELL_LEFT   = 10'd200;
    localparam coord_t WELL_BOTTOM = 10'd400;
    localparam coord_t WELL_RIGHT  = coord_t'(WELL_LEFT + CELL_COLS * CELL_SIZE);  // 400

    // frame bars are this thick on every side
    localparam coord_t BORDER_W    = 10'd20;

    // pause symbol, two upright bars
    localparam coord_t PAUSE1_X    = 10'd20;
    localparam coord_t PAUSE2_X    = 10'd40;
    localparam coord_t PAUSE_Y     = 10'd10;
    localparam coord_t PAUSE_W     = 10'd10;
    localparam coord_t PAUSE_H     = 10'd20;

    // ----------------------------------------
    // palette
    localparam pixel_t COLOR_PIECE = 24'hff_ff_00;  // yellow
    localparam pixel_t COLOR_WALL  = 24'hff_ff_ff;
    localparam pixel_t COLOR_BLOCK = 24'hff_14_93;  // pink
    localparam pixel_t COLOR_PAUSE = 24'hff_ff_ff;
    localparam pixel_t COLOR_BLANK = 24'h00_00_00;

    // half-open box test, one extra bit so x0 + w cannot wrap
    function automatic logic in_box(input coord_t x, input coord_t y,
                                    input coord_t x0, input coord_t y0,
                                    input coord_t w, input coord_t h);
        logic [$bits(coord_t):0] x_end;
        logic [$bits(coord_t):0] y_end;
        x_end = {1'b0, x0} + {1'b0, w};
        y_end = {1'b0, y0} + {1'b0, h};
        return (x >= x0) && ({1'b0, x} < x_end) &&
               (y >= y0) && ({1'b0, y} < y_end);
    endfunction

endpackage

// File: common/layer_hit_if.sv
// layer hit bundle: per-pixel flags from the layer detectors to the priority stage
`timescale 1ns/1ps

interface layer_hit_if;

    logic piece_hit;   // falling piece square
    logic wall_hit;    // well border
    logic block_hit;   // settled cell
    logic pause_hit;   // pause bar, already gated

    // each detector drives only its own flags
    modport detect (
        output piece_hit,
        output wall_hit,
        output block_hit,
        output pause_hit
    );

    modport choose (
        input piece_hit,
        input wall_hit,
        input block_hit,
        input pause_hit
    );

endinterface

// File: source/playfield_cells.sv
// playfield cells: settled-block memory with a strobed write port and per-pixel lookup
`timescale 1ns/1ps

module playfield_cells (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_cell_wr,
    input  mapper_pkg::row_t   i_cell_row,
    input  mapper_pkg::col_t   i_cell_col,
    input  logic               i_cell_fill,
    input  mapper_pkg::coord_t i_draw_x,
    input  mapper_pkg::coord_t i_draw_y,
    layer_hit_if.detect        hits
);
    import mapper_pkg::*;

    logic [CELL_COLS-1:0] cells [CELL_ROWS];  // bit per cell
    logic   in_well;
    coord_t rel_x;
    row_t   look_row;
    col_t   look_col;

    // ----------------------------------------
    // write side, one cell per strobe
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            cells <= '{default: '0};
        end
        else if (i_cell_wr)
        begin
            cells[i_cell_row][i_cell_col] <= i_cell_fill;
        end
    end

    // ----------------------------------------
    // read side, scan position to cell
    assign in_well = in_box(i_draw_x, i_draw_y, WELL_LEFT, '0,
                            WELL_RIGHT - WELL_LEFT, WELL_BOTTOM);
    assign rel_x   = i_draw_x - WELL_LEFT;

    always_comb
    begin
        look_row = '0;
        look_col = '0;
        if (in_well)
        begin
            look_row = row_t'(i_draw_y / CELL_SIZE);
            look_col = col_t'(rel_x / CELL_SIZE);
        end
    end

    // same-edge write is not seen here, the array updates after the sample
    assign hits.block_hit = in_well & cells[look_row][look_col];

    // the game logic only addresses cells inside the well
    a_write_in_grid : assert property (@(posedge i_clk) disable iff (i_reset)
        i_cell_wr |-> (i_cell_row < CELL_ROWS) && (i_cell_col < CELL_COLS))
    else $error("cell write outside grid: row %0d col %0d", i_cell_row, i_cell_col);

endmodule

// File: source/piece_hit.sv
// piece hit: tests the scan position against every square of the falling piece
`timescale 1ns/1ps

module piece_hit #(
    parameter int NUM_BLOCKS = 4
) (
    input  mapper_pkg::coord_t i_draw_x,
    input  mapper_pkg::coord_t i_draw_y,
    input  mapper_pkg::coord_t i_block_x [NUM_BLOCKS],
    input  mapper_pkg::coord_t i_block_y [NUM_BLOCKS],
    input  mapper_pkg::coord_t i_block_size,
    layer_hit_if.detect        hits
);
    import mapper_pkg::*;

    logic [NUM_BLOCKS-1:0] box_hit;  // one flag per square

    // ----------------------------------------
    // one comparator per square
    for (genvar k = 0; k < NUM_BLOCKS; k++)
    begin : g_square
        // squares are size by size, top left at (block_x, block_y)
        assign box_hit[k] = in_box(i_draw_x, i_draw_y,
                                   i_block_x[k], i_block_y[k],
                                   i_block_size, i_block_size);
    end

    // overlapping squares simply merge
    assign hits.piece_hit = |box_hit;

endmodule

// File: source/frame_overlay.sv
// frame overlay: decodes the well border bars and the pause symbol
`timescale 1ns/1ps

module frame_overlay (
    input  mapper_pkg::coord_t i_draw_x,
    input  mapper_pkg::coord_t i_draw_y,
    input  logic               i_pause,
    layer_hit_if.detect        hits
);
    import mapper_pkg::*;

    // ----------------------------------------
    // border rectangles around the well
    localparam coord_t LEFT_X0 = WELL_LEFT - BORDER_W;        // 180
    localparam coord_t SIDE_H  = WELL_BOTTOM + BORDER_W;      // sides reach the floor bar
    localparam coord_t FLOOR_W = WELL_RIGHT - WELL_LEFT + BORDER_W + BORDER_W;

    logic left_bar;
    logic right_bar;
    logic floor_bar;
    logic pause_a;
    logic pause_b;

    assign left_bar  = in_box(i_draw_x, i_draw_y, LEFT_X0, '0, BORDER_W, SIDE_H);
    assign right_bar = in_box(i_draw_x, i_draw_y, WELL_RIGHT, '0, BORDER_W, SIDE_H);
    assign floor_bar = in_box(i_draw_x, i_draw_y, LEFT_X0, WELL_BOTTOM,
                              FLOOR_W, BORDER_W);

    assign hits.wall_hit = left_bar | right_bar | floor_bar;

    // ----------------------------------------
    // pause bars, top left corner of the screen
    assign pause_a = in_box(i_draw_x, i_draw_y, PAUSE1_X, PAUSE_Y, PAUSE_W, PAUSE_H);
    assign pause_b = in_box(i_draw_x, i_draw_y, PAUSE2_X, PAUSE_Y, PAUSE_W, PAUSE_H);

    // only shown while paused
    assign hits.pause_hit = i_pause & (pause_a | pause_b);

endmodule

// File: source/pixel_priority.sv
// pixel priority: resolves the layer flags to one color and registers it
`timescale 1ns/1ps

module pixel_priority (
    input  logic               i_clk,
    input  logic               i_reset,
    layer_hit_if.choose        hits,
    output mapper_pkg::pixel_t o_pixel
);
    import mapper_pkg::*;

    pixel_t next_pixel;

    // ----------------------------------------
    // piece over wall over block over pause
    always_comb
    begin
        if (hits.piece_hit)
        begin
            next_pixel = COLOR_PIECE;
        end
        else if (hits.wall_hit)
        begin
            next_pixel = COLOR_WALL;
        end
        else if (hits.block_hit)
        begin
            next_pixel = COLOR_BLOCK;
        end
        else if (hits.pause_hit)
        begin
            next_pixel = COLOR_PAUSE;
        end
        else
        begin
            next_pixel = COLOR_BLANK;    // background
        end
    end

    // ----------------------------------------
    // the single output stage
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_pixel <= COLOR_BLANK;
        end
        else
        begin
            o_pixel <= next_pixel;
        end
    end

    // every detector flag must resolve, or x reaches the display
    a_flags_known : assert property (@(posedge i_clk) disable iff (i_reset)
        !$isunknown({hits.piece_hit, hits.wall_hit, hits.block_hit, hits.pause_hit}))
    else $error("layer flags unknown: %b",
                {hits.piece_hit, hits.wall_hit, hits.block_hit, hits.pause_hit});

endmodule

// File: source/color_mapper.sv
// color mapper: per-pixel color stage of the puzzle display, one cycle latency
`timescale 1ns/1ps

module color_mapper #(
    parameter int NUM_BLOCKS = 4
) (
    input  logic               Clk,
    input  logic               Reset,
    // scan position
    input  mapper_pkg::coord_t i_draw_x,
    input  mapper_pkg::coord_t i_draw_y,
    // falling piece
    input  mapper_pkg::coord_t i_block_x [NUM_BLOCKS],
    input  mapper_pkg::coord_t i_block_y [NUM_BLOCKS],
    input  mapper_pkg::coord_t i_block_size,
    input  logic               i_pause,
    // settled cell writes from the game logic
    input  logic               i_cell_wr,
    input  mapper_pkg::row_t   i_cell_row,
    input  mapper_pkg::col_t   i_cell_col,
    input  logic               i_cell_fill,
    // color out
    output mapper_pkg::color_t o_red,
    output mapper_pkg::color_t o_green,
    output mapper_pkg::color_t o_blue
);
    import mapper_pkg::*;

    pixel_t pixel;

    layer_hit_if hits ();

    // ----------------------------------------
    // layer detectors
    playfield_cells playfield_cells_i (
        .i_clk       (Clk),
        .i_reset     (Reset),
        .i_cell_wr   (i_cell_wr),
        .i_cell_row  (i_cell_row),
        .i_cell_col  (i_cell_col),
        .i_cell_fill (i_cell_fill),
        .i_draw_x    (i_draw_x),
        .i_draw_y    (i_draw_y),
        .hits        (hits)
    );

    piece_hit #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) piece_hit_i (
        .i_draw_x     (i_draw_x),
        .i_draw_y     (i_draw_y),
        .i_block_x    (i_block_x),
        .i_block_y    (i_block_y),
        .i_block_size (i_block_size),
        .hits         (hits)
    );

    frame_overlay frame_overlay_i (
        .i_draw_x (i_draw_x),
        .i_draw_y (i_draw_y),
        .i_pause  (i_pause),
        .hits     (hits)
    );

    // ----------------------------------------
    // priority and output register
    pixel_priority pixel_priority_i (
        .i_clk   (Clk),
        .i_reset (Reset),
        .hits    (hits),
        .o_pixel (pixel)
    );

    assign o_red   = pixel[23:16];
    assign o_green = pixel[15:8];
    assign o_blue  = pixel[7:0];

endmodule

// File: sim/tb_color_mapper.sv
// color mapper testbench: directed layer checks and a pipelined random sweep
`timescale 1ns/1ps

module tb_color_mapper;

    localparam int          CLK_PERIOD     = 8;
    localparam int          SETTLE_TIMEOUT = 20;   // cycles
    localparam int          SWEEP_PIXELS   = 300;
    localparam logic [31:0] SEED           = 32'he33a_2a59;

    localparam logic [23:0] YELLOW = 24'hff_ff_00;
    localparam logic [23:0] WHITE  = 24'hff_ff_ff;
    localparam logic [23:0] PINK   = 24'hff_14_93;
    localparam logic [23:0] BLACK  = 24'h00_00_00;

    logic       Clk;
    logic       Reset;
    logic [9:0] draw_x;
    logic [9:0] draw_y;
    logic [9:0] block_x [4];
    logic [9:0] block_y [4];
    logic [9:0] block_size;
    logic       pause;
    logic       cell_wr;
    logic [4:0] cell_row;
    logic [3:0] cell_col;
    logic       cell_fill;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    logic [9:0]  model_cells [20];  // expected well contents
    logic [31:0] rng_state;

    color_mapper #(
        .NUM_BLOCKS (4)
    ) color_mapper_i (
        .Clk          (Clk),
        .Reset        (Reset),
        .i_draw_x     (draw_x),
        .i_draw_y     (draw_y),
        .i_block_x    (block_x),
        .i_block_y    (block_y),
        .i_block_size (block_size),
        .i_pause      (pause),
        .i_cell_wr    (cell_wr),
        .i_cell_row   (cell_row),
        .i_cell_col   (cell_col),
        .i_cell_fill  (cell_fill),
        .o_red        (red),
        .o_green      (green),
        .o_blue       (blue)
    );

    initial
    begin
        Clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) Clk = ~Clk;
        end
    end

    // ----------------------------------------
    // helpers
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int span);
        logic [31:0] r;
        r = lcg_next();
        return lo + int'(r[23:8]) % span;  // low bits of an lcg are weak
    endfunction

    // piece over wall over block over pause over black
    function automatic logic [23:0] ref_color(input int x, input int y);
        logic piece;
        logic wall;
        logic block;
        logic bar;
        piece = 1'b0;
        block = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            if (x >= int'(block_x[k]) && x < int'(block_x[k]) + int'(block_size) &&
                y >= int'(block_y[k]) && y < int'(block_y[k]) + int'(block_size))
                piece = 1'b1;
        end
        wall = (x >= 180 && x <= 199 && y <= 419) ||
               (x >= 400 && x <= 419 && y <= 419) ||
               (x >= 180 && x <= 419 && y >= 400 && y <= 419);
        if (x >= 200 && x <= 399 && y <= 399)
            block = model_cells[y / 20][(x - 200) / 20];
        bar = pause && y >= 10 && y <= 29 &&
              ((x >= 20 && x <= 29) || (x >= 40 && x <= 49));
        if (piece)
            return YELLOW;
        else if (wall)
            return WHITE;
        else if (block)
            return PINK;
        else if (bar)
            return WHITE;
        else
            return BLACK;
    endfunction

    task automatic next_cycle();
        @(posedge Clk);
        #1;  // drive and sample point
    endtask

    task automatic check_color(input logic [23:0] expected, input int x, input int y);
        logic [23:0] actual;
        actual = {red, green, blue};
        assert (actual === expected)
        else
        begin
            $display("MISMATCH at %0t ns: pixel (%0d,%0d) expected %h got %h",
                     $time, x, y, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "color check failed");
        end
    endtask

    // one pixel in, its color one edge later
    task automatic check_pixel(input int x, input int y);
        logic [23:0] expected;
        draw_x   = 10'(x);
        draw_y   = 10'(y);
        expected = ref_color(x, y);
        next_cycle();
        check_color(expected, x, y);
    endtask

    task automatic write_cell(input int row, input int col, input logic fill);
        cell_wr   = 1'b1;
        cell_row  = 5'(row);
        cell_col  = 4'(col);
        cell_fill = fill;
        next_cycle();
        cell_wr = 1'b0;
        model_cells[row][col] = fill;
    endtask

    // whole cell plus a one pixel ring around it
    task automatic check_cell(input int row, input int col);
        for (int dy = -1; dy <= 20; dy++)
        begin
            for (int dx = -1; dx <= 20; dx++)
            begin
                if (row * 20 + dy >= 0)
                    check_pixel(200 + col * 20 + dx, row * 20 + dy);
            end
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while ({red, green, blue} !== BLACK && cycles < SETTLE_TIMEOUT)
        begin
            next_cycle();
            cycles++;
        end
        assert ({red, green, blue} === BLACK)
        else
        begin
            $display("outputs not black within %0d cycles of reset release", SETTLE_TIMEOUT);
            $display("TEST FAILED");
            $fatal(1, "reset timeout");
        end
    endtask

    // ----------------------------------------
    // directed tests
    task automatic after_reset_blank();
        for (int i = 0; i < 20; i++)
            check_pixel(200 + i * 10, i * 20);
        check_pixel(399, 399);
        check_pixel(25, 15);  // pause bars while not paused
        check_pixel(45, 25);
    endtask

    task automatic border_bars();
        check_pixel(180, 0);
        check_pixel(199, 419);
        check_pixel(190, 200);
        check_pixel(400, 0);
        check_pixel(419, 419);
        check_pixel(410, 100);
        check_pixel(300, 400);
        check_pixel(180, 410);
        check_pixel(419, 405);
        // just outside each bar
        check_pixel(179, 200);
        check_pixel(200, 200);
        check_pixel(399, 200);
        check_pixel(420, 200);
        check_pixel(300, 420);
        check_pixel(179, 410);
        check_pixel(420, 410);
    endtask

    task automatic cell_writes();
        write_cell(0, 0, 1'b1);
        write_cell(19, 9, 1'b1);
        write_cell(7, 3, 1'b1);
        check_cell(0, 0);
        check_cell(19, 9);
        check_cell(7, 3);
        write_cell(7, 3, 1'b0);
        check_pixel(270, 150);  // first pixel after the clear
        check_cell(7, 3);
    endtask

    task automatic falling_piece();
        block_size = 10'd20;
        block_x[0] = 10'd210;   // over filled cell (0,0)
        block_y[0] = 10'd5;
        block_x[1] = 10'd190;   // over the left wall
        block_y[1] = 10'd200;
        block_x[2] = 10'd300;
        block_y[2] = 10'd300;
        block_x[3] = 10'd320;
        block_y[3] = 10'd300;
        for (int k = 0; k < 4; k++)
        begin
            for (int dy = -1; dy <= 20; dy++)
            begin
                for (int dx = -1; dx <= 20; dx++)
                    check_pixel(int'(block_x[k]) + dx, int'(block_y[k]) + dy);
            end
        end
        block_size = 10'd0;
    endtask

    task automatic pause_bars();
        pause = 1'b1;
        for (int x = 15; x <= 55; x++)
            check_pixel(x, 20);
        check_pixel(25, 9);
        check_pixel(25, 10);
        check_pixel(45, 29);
        check_pixel(45, 30);
        pause = 1'b0;
        check_pixel(25, 15);
        check_pixel(45, 15);
    endtask

    // back to back pixels, each checked on the following cycle
    task automatic random_sweep();
        logic [23:0] expected;
        int          x;
        int          y;
        int          row;
        int          col;
        expected   = BLACK;
        x          = 0;
        y          = 0;
        row        = 0;
        col        = 0;
        block_size = 10'd20;
        for (int i = 0; i < SWEEP_PIXELS; i++)
        begin
            if (i > 0)
                check_color(expected, x, y);
            if (i % 25 == 0)
            begin
                for (int k = 0; k < 4; k++)
                begin
                    block_x[k] = 10'(rand_range(190, 220));
                    block_y[k] = 10'(rand_range(0, 400));
                end
                pause = 1'(rand_range(0, 2));
            end
            if (rand_range(0, 4) == 0)
            begin
                x = rand_range(0, 64);   // pause corner
                y = rand_range(0, 40);
            end
            else
            begin
                x = rand_range(170, 260);
                y = rand_range(0, 430);
            end
            draw_x   = 10'(x);
            draw_y   = 10'(y);
            expected = ref_color(x, y);
            cell_wr  = 1'b0;
            if (rand_range(0, 3) == 0)
            begin
                row       = rand_range(0, 20);
                col       = rand_range(0, 10);
                cell_wr   = 1'b1;
                cell_row  = 5'(row);
                cell_col  = 4'(col);
                cell_fill = 1'(rand_range(0, 2));
            end
            next_cycle();
            if (cell_wr)
                model_cells[row][col] = cell_fill;
        end
        check_color(expected, x, y);
        cell_wr    = 1'b0;
        block_size = 10'd0;
        pause      = 1'b0;
    endtask

    // ----------------------------------------
    initial
    begin
        Reset      = 1'b1;
        draw_x     = '0;
        draw_y     = '0;
        block_size = '0;
        pause      = 1'b0;
        cell_wr    = 1'b0;
        cell_row   = '0;
        cell_col   = '0;
        cell_fill  = 1'b0;
        rng_state  = SEED;
        for (int k = 0; k < 4; k++)
        begin
            block_x[k] = '0;
            block_y[k] = '0;
        end
        for (int r = 0; r < 20; r++)
            model_cells[r] = '0;
        repeat (16) @(posedge Clk);
        #1;
        Reset = 1'b0;
        wait_reset_done();

        after_reset_blank();
        border_bars();
        cell_writes();
        falling_piece();
        pause_bars();
        random_sweep();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: project.f
common/mapper_pkg.sv
common/layer_hit_if.sv
source/playfield_cells.sv
source/piece_hit.sv
source/frame_overlay.sv
source/pixel_priority.sv
source/color_mapper.sv
sim/tb_color_mapper.sv

// File: Makefile
# Verilator build and run of the color mapper testbench

TOP       ?= tb_color_mapper
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= project.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: TOP SIM_DIR LOG FILELIST VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)
	-$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)
